// File: Bender.yml
package:
  name: decode_stage

sources:
  - core_cfg_pkg.sv
  - rv_isa_pkg.sv
  - instr_capture.sv
  - m_illegalop.sv
  - instr_classify.sv
  - trap_capture.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv

// File: build.f
core_cfg_pkg.sv
rv_isa_pkg.sv
instr_capture.sv
m_illegalop.sv
instr_classify.sv
trap_capture.sv
decode_stage.sv
tb_decode_stage.sv

// File: core_cfg_pkg.sv
// ========================================
// build configuration for the decode front end
// ========================================
package core_cfg_pkg;

   // checker decode depth
   // 0 full decode
   // 1 skip funct7 and rs1/rd checks
   // 2 only look at bit 0
   localparam int cfg_lazy_decode = 0;

   // M extension legal when set
   localparam int cfg_muldiv = 1;

   // ========================================
   // trap cause codes, mcause encoding
   // ========================================
   localparam logic [3:0] cause_illegal_instr = 4'd2;   // illegal instruction

endpackage

// File: decode_stage.sv
`timescale 1ns/10ps

// decode front end top
module decode_stage (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req,
   input  logic [31:0] instr,
   input  logic        corerunning,
   input  logic        trap_clear,
   output logic        ack,
   output logic        dec_valid,
   output logic [2:0]  instr_class,
   output logic [4:0]  rd,
   output logic [4:0]  rs1,
   output logic [4:0]  rs2,
   output logic [31:0] imm,
   output logic        illegal,
   output logic        trap_pending,
   output logic [3:0]  trap_cause,
   output logic [31:0] trap_val
);

   logic [31:0] cur_instr;   // held word
   logic        dec_new;     // capture pulse

   instr_capture u_capture (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .instr        (instr),
      .trap_pending (trap_pending),
      .ack          (ack),
      .cur_instr    (cur_instr),
      .dec_valid    (dec_valid),
      .dec_new      (dec_new)
   );

   // full decode, M extension on
   m_illegalop #(
      .lazy_decode (0),
      .muldiv      (1)
   ) u_illegal (
      .instr       (cur_instr),
      .corerunning (corerunning),
      .illegal     (illegal)
   );

   instr_classify u_classify (
      .instr       (cur_instr),
      .instr_class (instr_class),
      .rd          (rd),
      .rs1         (rs1),
      .rs2         (rs2),
      .imm         (imm)
   );

   trap_capture u_trap (
      .clk          (clk),
      .rst_n        (rst_n),
      .dec_new      (dec_new),
      .illegal      (illegal),
      .cur_instr    (cur_instr),
      .trap_clear   (trap_clear),
      .trap_pending (trap_pending),
      .trap_cause   (trap_cause),
      .trap_val     (trap_val)
   );

endmodule

// File: instr_capture.sv
`timescale 1ns/10ps

// four-phase receiver, one held instruction
module instr_capture (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req,            // fetch request
   input  logic [31:0] instr,          // stable while req high
   input  logic        trap_pending,   // microcode has not collected the trap yet
   output logic        ack,
   output logic [31:0] cur_instr,
   output logic        dec_valid,
   output logic        dec_new         // one cycle at capture
);

   logic held;   // a word sits in cur_instr
   logic take;   // accept a new word this edge
   logic drop;   // fetch released, finish the handshake

   // no new word while a trap waits, keeps the bad word in place
   assign take = req & ~held & ~trap_pending;
   assign drop = ~req & held;

   // ========================================
   // handshake state
   // ========================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         held    <= 1'b0;
         dec_new <= 1'b0;
      end else begin
         dec_new <= take;           // pulse only on the capture edge
         if (take) begin
            held <= 1'b1;
         end else if (drop) begin
            held <= 1'b0;           // ack falls, decode no longer valid
         end
      end
   end

   // instruction register
   always_ff @(posedge clk) begin
      if (take) begin
         cur_instr <= instr;
      end
   end

   assign ack       = held;   // ack stays up until req drops
   assign dec_valid = held;

endmodule

// File: instr_classify.sv
`timescale 1ns/10ps

// class, register fields and immediate of the held word
module instr_classify
   import rv_isa_pkg::*;
(
   input  instr_word_u instr,
   output logic [2:0]  instr_class,
   output logic [4:0]  rd,
   output logic [4:0]  rs1,
   output logic [4:0]  rs2,
   output logic [31:0] imm
);

   logic [31:0] raw;   // flat view for the scattered immediates

   assign raw = instr;

   // register fields straight from the word
   assign rd  = instr.r.rd;
   assign rs1 = instr.i.rs1;
   assign rs2 = instr.r.rs2;   // shamt on shift-imm

   // ========================================
   // opcode to class
   // ========================================
   always_comb begin
      case (instr.r.opcode)
         opc_op:       instr_class = cls_alu;
         opc_op_imm:   instr_class = cls_alu_imm;
         opc_load:     instr_class = cls_load;
         opc_store:    instr_class = cls_store;
         opc_branch:   instr_class = cls_branch;
         opc_jal,
         opc_jalr:     instr_class = cls_jump;
         opc_lui,
         opc_auipc:    instr_class = cls_upper;
         opc_system,
         opc_misc_mem: instr_class = cls_system;
         default:      instr_class = cls_system;   // illegal anyway
      endcase
   end

   // ========================================
   // immediate format from class
   // ========================================
   always_comb begin
      case (instr_class)
         cls_alu_imm,
         cls_load:   imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};             // I
         cls_store:  imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};              // S
         cls_branch: imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25],
                            raw[11:8], 1'b0};                                   // B
         cls_upper:  imm = {raw[31:12], 12'b0};                                 // U
         cls_jump: begin
            if (instr.r.opcode[3]) begin                                        // jal, J
               imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            end else begin                                                      // jalr, I
               imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
            end
         end
         default:    imm = 32'd0;   // R-type and system
      endcase
   end

endmodule

// File: m_illegalop.sv
`timescale 1ns/10ps

// illegal instruction check, pure combinational
module m_illegalop
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
#(
   parameter int lazy_decode = cfg_lazy_decode,
   parameter int muldiv      = cfg_muldiv
) (
   input  instr_word_u instr,
   input  logic        corerunning,   // nothing is flagged while halted
   output logic        illegal
);

   generate
      if (lazy_decode == 2) begin : g_bit0
         // cheapest form, only the low bit
         assign illegal = ~instr.r.opcode[0] & corerunning;
      end else begin : g_table
         logic [1:0] tab;        // {bit6 set, bit6 clear} bad flags
         logic       main_bad;   // major opcode or low bits wrong

         // ========================================
         // major opcode table on bits 5:2
         // ========================================
         always_comb begin
            case (instr.r.opcode[5:2])
               4'b0000: tab = 2'b10;   // load
               4'b0001: tab = 2'b11;
               4'b0010: tab = 2'b11;   // custom space, not legal here
               4'b0011: tab = 2'b10;   // fence
               4'b0100: tab = 2'b10;   // op-imm
               4'b0101: tab = 2'b10;   // auipc
               4'b0110: tab = 2'b11;
               4'b0111: tab = 2'b11;
               4'b1000: tab = 2'b00;   // branch / store
               4'b1001: tab = 2'b01;   // jalr
               4'b1010: tab = 2'b11;
               4'b1011: tab = 2'b01;   // jal
               4'b1100: tab = 2'b00;   // system / op
               4'b1101: tab = 2'b10;   // lui
               default: tab = 2'b11;   // 1110, 1111 unused
            endcase
         end

         assign main_bad = (instr.r.opcode[6] ? tab[1] : tab[0])
                           | ~instr.r.opcode[1] | ~instr.r.opcode[0];

         if (lazy_decode == 1) begin : g_lazy
            assign illegal = main_bad & corerunning;
         end else begin : g_full
            logic check_f7;      // shift-imm or register alu op
            logic f7_5_free;     // funct7[5] allowed, sub / sra / srai
            logic f7_rest_bad;   // any other funct7 bit set where not allowed
            logic check_rs1_rd;  // ecall, ebreak, wfi, mret group
            logic bad_rs1_rd;

            // slli/srli/srai or any OP word
            assign check_f7 = (instr.r.opcode[5:4] == 2'b01 && !instr.r.opcode[2]
                               && instr.r.funct3[1:0] == 2'b01)
                              | (instr.r.opcode[6:4] == 3'b011 && !instr.r.opcode[2]);

            if (muldiv == 0) begin : g_no_m
               assign f7_5_free   = (!instr.r.opcode[5] && instr.r.funct3[2])
                                    || (instr.r.opcode[5] && (instr.r.funct3 == 3'b000
                                                              || instr.r.funct3 == 3'b101));
               assign f7_rest_bad = {instr.r.funct7[6], instr.r.funct7[4:0]} != 6'h0;
            end else begin : g_m
               // bit 0 picks the M ops on OP, never with bit 5
               assign f7_5_free   = (!instr.r.opcode[5] && instr.r.funct3[2])
                                    || (instr.r.opcode[5] && !instr.r.funct7[0]
                                        && (instr.r.funct3 == 3'b000
                                            || instr.r.funct3 == 3'b101));
               assign f7_rest_bad = ({instr.r.funct7[6], instr.r.funct7[4:1]} != 5'h0)
                                    || (!instr.r.opcode[5] && instr.r.funct7[0]);   // shamt[5]
            end

            // system with funct3 x00 wants rs1 and rd zero
            assign check_rs1_rd = instr.r.opcode[6] && instr.r.opcode[4]
                                  && instr.r.funct3[1:0] == 2'b00;
            assign bad_rs1_rd   = check_rs1_rd && (instr.r.rs1 != 5'd0 || instr.r.rd != 5'd0);

            assign illegal = (main_bad
                              | (check_f7 & f7_rest_bad)
                              | (check_f7 & ~f7_5_free & instr.r.funct7[5])
                              | bad_rs1_rd) & corerunning;
         end
      end
   endgenerate

endmodule

// File: rv_isa_pkg.sv
// ========================================
// rv32 major opcodes
// ========================================
package rv_isa_pkg;

   localparam logic [6:0] opc_load     = 7'b0000011;
   localparam logic [6:0] opc_misc_mem = 7'b0001111;   // fence
   localparam logic [6:0] opc_op_imm   = 7'b0010011;
   localparam logic [6:0] opc_auipc    = 7'b0010111;
   localparam logic [6:0] opc_store    = 7'b0100011;
   localparam logic [6:0] opc_op       = 7'b0110011;   // reg-reg alu and M ops
   localparam logic [6:0] opc_lui      = 7'b0110111;
   localparam logic [6:0] opc_branch   = 7'b1100011;
   localparam logic [6:0] opc_jalr     = 7'b1100111;
   localparam logic [6:0] opc_jal      = 7'b1101111;
   localparam logic [6:0] opc_system   = 7'b1110011;   // ecall, ebreak, csr, mret

   // ========================================
   // instruction class codes
   // ========================================
   localparam logic [2:0] cls_alu     = 3'd0;   // register alu, no immediate
   localparam logic [2:0] cls_alu_imm = 3'd1;
   localparam logic [2:0] cls_load    = 3'd2;
   localparam logic [2:0] cls_store   = 3'd3;
   localparam logic [2:0] cls_branch  = 3'd4;
   localparam logic [2:0] cls_jump    = 3'd5;   // jal and jalr
   localparam logic [2:0] cls_upper   = 3'd6;   // lui and auipc
   localparam logic [2:0] cls_system  = 3'd7;   // system and fence

   // ========================================
   // one instruction word, two field layouts
   // ========================================
   typedef union packed {
      // register form
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      // immediate form
      struct packed {
         logic [11:0] imm12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
   } instr_word_u;

endpackage

// File: tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage
   import rv_isa_pkg::*;
;

   localparam int num_rows = 24;
   localparam int num_rand = 40;
   // each fetch gets 20 cycles of 4 ns plus margin
   localparam int run_limit_ns = (2 * num_rows + num_rand) * 20 * 4 + 400;

   logic        clk, rst_n, req, corerunning, trap_clear;
   logic [31:0] instr;
   logic        ack, dec_valid, illegal, trap_pending;
   logic [2:0]  instr_class;
   logic [4:0]  rd, rs1, rs2;
   logic [31:0] imm, trap_val;
   logic [3:0]  trap_cause;

   typedef struct packed {
      logic [31:0] w;             // word handed to decode
      logic        run, ill, chk; // corerunning, expected illegal, compare fields
      logic [2:0]  cls;
      logic [4:0]  rd, rs1, rs2;
      logic [31:0] imm;
   } row_t;

   row_t        rows[$];
   row_t        cur;
   int          errors = 0;
   int          checks = 0;
   logic [31:0] rnd = 32'd35825;   // xorshift state
   logic        pending;           // trap left from the previous fetch

   decode_stage dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns
   end

   initial begin
      #(run_limit_ns);
      $display("timeout, the fetch handshake did not finish within %0d ns", run_limit_ns);
      $display("Test FAILED");
      $finish;
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic add_row(input logic [31:0] w, input logic run, input logic ill,
                          input logic [2:0] cls, input logic [4:0] f_rd, f_rs1, f_rs2,
                          input logic [31:0] f_imm);
      rows.push_back('{w, run, ill, ~ill & run, cls, f_rd, f_rs1, f_rs2, f_imm});
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ========================================
   // legality rule for full decode with M
   // ========================================
   function automatic logic ref_illegal(input logic [31:0] w);
      logic [6:0] op;
      logic [2:0] f3;
      logic [6:0] f7;
      logic       ok;
      op = w[6:0];
      f3 = w[14:12];
      f7 = w[31:25];
      case (op)
         opc_load, opc_op_imm, opc_auipc, opc_store, opc_op, opc_lui,
         opc_branch, opc_jalr, opc_jal, opc_system, opc_misc_mem: ok = 1'b1;
         default: ok = 1'b0;
      endcase
      if (op == opc_op)   // base, sub/sra, or M
         ok = f7 == 7'h00 || f7 == 7'h01 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      if (op == opc_op_imm && f3[1:0] == 2'b01)   // shift immediates
         ok = f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b101);
      if (op == opc_system && f3[1:0] == 2'b00)
         ok = w[19:15] == 5'd0 && w[11:7] == 5'd0;
      return ~ok;
   endfunction

   // fetch side lets go and ack must follow
   task automatic drop_req();
      int n;
      @(posedge clk);
      req <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (ack && n < 8);
      if (ack) begin
         errors++;
         $display("ack still high %0d cycles after req dropped", n);
      end
      check_val("dec_valid", dec_valid, 1'b0);
   endtask

   // ========================================
   // one four-phase transfer plus checks
   // ========================================
   task automatic run_fetch(input row_t r, input logic blocked);
      int n;
      @(posedge clk);
      instr       <= r.w;
      corerunning <= r.run;
      req         <= 1'b1;
      if (blocked) begin
         repeat (4) begin
            @(negedge clk);
            check_val("ack", ack, 1'b0);   // held off by the pending trap
            check_val("dec_valid", dec_valid, 1'b0);
         end
         @(posedge clk);
         trap_clear <= 1'b1;   // microcode collects the trap
         @(posedge clk);
         trap_clear <= 1'b0;
      end
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ack && n < 8);
      if (!ack) begin
         errors++;
         $display("no ack within %0d cycles of req", n);
      end else begin
         check_val("ack_latency", n, 2);   // captured on the first edge
      end
      check_val("dec_valid", dec_valid, 1'b1);
      check_val("trap_pending", trap_pending, 1'b0);
      check_val("illegal", illegal, r.ill);
      if (r.chk) begin
         check_val("instr_class", instr_class, r.cls);
         check_val("rd", rd, r.rd);
         check_val("rs1", rs1, r.rs1);
         check_val("rs2", rs2, r.rs2);
         check_val("imm", imm, r.imm);
      end
      @(negedge clk);
      check_val("trap_pending", trap_pending, r.ill & r.run);   // one cycle after ack
      if (r.ill & r.run) begin
         check_val("trap_cause", trap_cause, 4'd2);
         check_val("trap_val", trap_val, r.w);
      end
      drop_req();
   endtask

   initial begin
      rst_n       = 1'b0;
      req         = 1'b0;
      instr       = 32'd0;
      corerunning = 1'b1;
      trap_clear  = 1'b0;
      // legal words with expected fields from the raw bit positions
      add_row({12'hffc, 5'd2, 3'b010, 5'd5, opc_load}, 1, 0, cls_load, 5, 2, 28, -4);
      add_row({7'h7f, 5'd7, 5'd3, 3'b010, 5'h18, opc_store}, 1, 0, cls_store, 24, 3, 7, -8);
      add_row({1'b1, 6'h3f, 5'd2, 5'd1, 3'b000, 4'b1000, 1'b1, opc_branch}, 1, 0, cls_branch,
              17, 1, 2, -16);                               // beq -16
      add_row({1'b1, 10'h000, 1'b1, 8'hff, 5'd1, opc_jal}, 1, 0, cls_jump, 1, 31, 1, -2048);
      add_row({12'd12, 5'd1, 3'b000, 5'd0, opc_jalr}, 1, 0, cls_jump, 0, 1, 12, 12);
      add_row({20'h80000, 5'd10, opc_lui}, 1, 0, cls_upper, 10, 0, 0, 32'h80000000);
      add_row({20'h12345, 5'd3, opc_auipc}, 1, 0, cls_upper, 3, 8, 3, 32'h12345000);
      add_row({12'hfff, 5'd0, 3'b000, 5'd4, opc_op_imm}, 1, 0, cls_alu_imm, 4, 0, 31, -1);
      add_row({12'h003, 5'd6, 3'b001, 5'd6, opc_op_imm}, 1, 0, cls_alu_imm, 6, 6, 3, 3);
      add_row({12'h41f, 5'd6, 3'b101, 5'd6, opc_op_imm}, 1, 0, cls_alu_imm, 6, 6, 31, 'h41f);
      add_row({7'h00, 5'd3, 5'd2, 3'b000, 5'd1, opc_op}, 1, 0, cls_alu, 1, 2, 3, 0);   // add
      add_row({7'h20, 5'd3, 5'd2, 3'b000, 5'd1, opc_op}, 1, 0, cls_alu, 1, 2, 3, 0);   // sub
      add_row({7'h20, 5'd7, 5'd8, 3'b101, 5'd9, opc_op}, 1, 0, cls_alu, 9, 8, 7, 0);   // sra
      add_row({7'h01, 5'd7, 5'd6, 3'b000, 5'd5, opc_op}, 1, 0, cls_alu, 5, 6, 7, 0);   // mul
      add_row({7'h01, 5'd7, 5'd6, 3'b101, 5'd5, opc_op}, 1, 0, cls_alu, 5, 6, 7, 0);   // divu
      add_row({12'h0ff, 5'd0, 3'b000, 5'd0, opc_misc_mem}, 1, 0, cls_system, 0, 0, 31, 0);
      add_row({12'h000, 5'd0, 3'b000, 5'd0, opc_system}, 1, 0, cls_system, 0, 0, 0, 0);
      add_row({12'h302, 5'd0, 3'b000, 5'd0, opc_system}, 1, 0, cls_system, 0, 0, 2, 0);
      // illegal words whose fields are not compared
      add_row(32'h0000007f, 1, 1, 0, 0, 0, 0, 0);                          // bad opcode
      add_row({12'h001, 5'd0, 3'b000, 5'd1, 7'b0010001}, 1, 1, 0, 0, 0, 0, 0);
      add_row({12'h403, 5'd6, 3'b001, 5'd6, opc_op_imm}, 1, 1, 0, 0, 0, 0, 0);   // slli f7
      add_row({7'h20, 5'd3, 5'd2, 3'b100, 5'd1, opc_op}, 1, 1, 0, 0, 0, 0, 0);   // xor f7
      add_row({12'h000, 5'd0, 3'b000, 5'd1, opc_system}, 1, 1, 0, 0, 0, 0, 0);   // ecall rd
      add_row(32'h0000007f, 0, 0, 0, 0, 0, 0, 0);                          // core halted

      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_val("ack", ack, 1'b0);
      check_val("dec_valid", dec_valid, 1'b0);
      check_val("trap_pending", trap_pending, 1'b0);
      check_val("trap_cause", trap_cause, 4'd0);
      check_val("trap_val", trap_val, 32'd0);

      pending = 1'b0;
      for (int pass = 0; pass < 2; pass++) begin
         foreach (rows[k]) begin
            run_fetch(rows[k], pending);
            pending = rows[k].ill & rows[k].run;
         end
         if (pass == 0) begin
            for (int k = 0; k < num_rand; k++) begin
               rnd   = xorshift(rnd);
               cur   = '0;
               cur.w = rnd;
               if (rnd[31])
                  cur.w[1:0] = 2'b11;   // more hits on real opcodes
               cur.run = 1'b1;
               cur.ill = ref_illegal(cur.w);
               run_fetch(cur, pending);
               pending = cur.ill;
            end
         end
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: trap_capture.sv
`timescale 1ns/10ps

// illegal instruction trap latch, cause and offending word
module trap_capture
   import core_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        dec_new,       // fresh word this cycle
   input  logic        illegal,
   input  logic [31:0] cur_instr,
   input  logic        trap_clear,    // microcode has read the trap
   output logic        trap_pending,
   output logic [3:0]  trap_cause,    // as mcause
   output logic [31:0] trap_val       // as mtval
);

   logic trap_set;

   // clear wins over a new set
   assign trap_set = dec_new & illegal & ~trap_clear;

   // ========================================
   // pending flag and trap registers
   // ========================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         trap_pending <= 1'b0;
         trap_cause   <= 4'd0;
         trap_val     <= 32'd0;
      end else begin
         if (trap_clear) begin
            trap_pending <= 1'b0;
         end else if (trap_set) begin
            trap_pending <= 1'b1;   // one cycle after ack rise
         end
         if (trap_set) begin
            trap_cause <= cause_illegal_instr;
            trap_val   <= cur_instr;   // still held, fetch cannot overwrite yet
         end
      end
   end

endmodule
